// File: lspcVideo.f
design/lspcPkg.sv
design/clockReset.sv
design/videoSync.sv
design/vramPort.sv
design/fixFetch.sv
design/autoAnim.sv
design/irqCtrl.sv
design/lspcVideo.sv
dv/lspcVideoChecks_sva.sv
dv/lspcVideoTb.sv

// File: Makefile
TOOL = verilator
FLAGS = --binary --timing --assert --timescale 1ns/1ps -j 0
TOP = lspcVideoTb
FILELIST = lspcVideo.f
LOG = sim.log

.PHONY: sim clean

# A crashed or aborted run counts as a failure too
sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || echo "*** FAILED ***" >> $(LOG)
	cat $(LOG)
	! grep -q -F "*** FAILED ***" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: dv/lspcVideoTb.sv
`timescale 1ns/1ps
`default_nettype none

module lspcVideoTb;

	localparam int hTotal = 64;
	localparam int vTotal = 40;
	localparam int hActive = 48;
	localparam int vActive = 24;
	localparam int lineCycles = hTotal * 4;		// Pixel enable is 1 in 4
	localparam int frameCycles = lineCycles * vTotal;

	// Wait conditions
	localparam int condResetUp = 0;
	localparam int condIplOne = 1;
	localparam int condLineLast = 2;
	localparam int condLineWrap = 3;
	localparam int condVBlank = 4;
	localparam int condActive = 5;
	localparam int condFixCell = 6;

	logic SNKCLK_26;
	logic rstN;
	lspcPkg::cpuBus cpu;
	logic [15:0] readData;
	lspcPkg::beamPos beam;
	lspcPkg::fixOut fixBus;
	logic [1:0] ipl;
	logic sync;
	logic resetP;
	logic pixelEn;

	int checks = 0;
	int errors = 0;
	int timeouts = 0;
	logic [31:0] lcgState = 32'd15;

	lspcVideo #(
		.hTotal(hTotal),
		.vTotal(vTotal),
		.hActive(hActive),
		.vActive(vActive)
	) uut (
		.SNKCLK_26(SNKCLK_26),
		.rstN(rstN),
		.cpu(cpu),
		.readData(readData),
		.beam(beam),
		.fixOut(fixBus),
		.ipl(ipl),
		.sync(sync),
		.resetP(resetP),
		.pixelEn(pixelEn)
	);

	always #50 SNKCLK_26 = ~SNKCLK_26;	// 100 ns period

	function automatic logic [15:0] lcgNext();
		lcgState = lcgState * 32'd1103515245 + 32'd12345;
		return lcgState[30:15];		// Upper bits, better spread
	endfunction

	function automatic bit condMet(input int which);
		case (which)
			condResetUp: return resetP == 1'b1;
			condIplOne: return ipl == 2'd1;
			condLineLast: return beam.hCount == 9'(hTotal - 1);
			condLineWrap: return beam.hCount != 9'(hTotal - 1);
			condVBlank: return beam.vBlank == 1'b1;
			condActive: return beam.vBlank == 1'b0;
			condFixCell: return beam.vCount == 9'd9 && beam.hCount == 9'd22;	// Row 1, col 2
			default: return 1'b0;
		endcase
	endfunction

	task automatic checkVal(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		assert (got == exp) else begin
			$display("CHECK FAILED t=%0t %s got=%0h exp=%0h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic idleCycles(input int n);
		repeat (n) begin
			@(posedge SNKCLK_26);
			#1;
		end
	endtask

	task automatic waitUntil(input int which, input int limit, input string what, output int waited);
		waited = 0;
		while (!condMet(which) && waited < limit) begin
			@(posedge SNKCLK_26);
			#1;
			waited++;
		end
		if (!condMet(which)) begin
			$display("Timeout after %0d cycles waiting for %s", limit, what);
			timeouts++;
		end
	endtask

	// One-cycle strobe, then leave the VRAM slot room to finish
	task automatic writeReg(input logic [2:0] sel, input logic [15:0] data);
		cpu.wrEn = 1'b1;
		cpu.regSel = sel;
		cpu.wrData = data;
		@(posedge SNKCLK_26);
		#1;
		cpu.wrEn = 1'b0;
		idleCycles(8);
	endtask

	task automatic readReg(input logic [2:0] sel, output logic [15:0] data);
		cpu.rdEn = 1'b1;
		cpu.regSel = sel;
		@(posedge SNKCLK_26);
		#1;
		cpu.rdEn = 1'b0;
		data = readData;		// Registered on the strobe edge
		idleCycles(8);
	endtask

	initial begin
		int w;
		logic [15:0] d;
		logic [15:0] base;
		logic [15:0] words [8];
		logic [3:0] pal;
		logic [11:0] tile;
		logic [16:0] fixExp;
		logic [8:0] prevH;
		logic lineStarted;
		logic syncMoved;
		logic lastSync;
		lspcPkg::modeWord mw;
		logic [2:0] aaBase;

		SNKCLK_26 = 1'b0;
		rstN = 1'b0;
		cpu = '0;
		syncMoved = 1'b0;
		lastSync = 1'b0;

		// Reset, then the level 3 interrupt
		repeat (5) @(posedge SNKCLK_26);
		#1;
		checkVal("pixelEn", 32'(pixelEn), 32'd0);
		checkVal("beam.hCount", 32'(beam.hCount), 32'd0);
		checkVal("ipl", 32'(ipl), 32'd0);
		checkVal("sync", 32'(sync), 32'd1);		// Both syncs inactive
		rstN = 1'b1;
		waitUntil(condResetUp, 20, "resetP release", w);
		checkVal("resetP delay", 32'(w), 32'd4);
		idleCycles(1);
		checkVal("ipl", 32'(ipl), 32'd3);
		writeReg(lspcPkg::regIrqAck, 16'h0001);
		checkVal("ipl", 32'(ipl), 32'd0);
		waitUntil(condIplOne, frameCycles + 200, "vblank interrupt", w);
		checkVal("beam.vCount", 32'(beam.vCount), 32'(vActive));
		writeReg(lspcPkg::regIrqAck, 16'h0004);
		checkVal("ipl", 32'(ipl), 32'd0);

		// Line wrap, then a full frame of blanking and sync
		waitUntil(condLineLast, lineCycles + 8, "hCount at line end", w);
		waitUntil(condLineWrap, 8, "hCount wrap", w);
		checkVal("beam.hCount", 32'(beam.hCount), 32'd0);
		prevH = beam.hCount;
		lineStarted = 1'b0;
		for (int i = 0; i < frameCycles + lineCycles * 2; i++) begin
			@(posedge SNKCLK_26);
			#1;
			checkVal("beam.vBlank", 32'(beam.vBlank), 32'(beam.vCount >= 9'(vActive)));
			checkVal("beam.hBlank", 32'(beam.hBlank), 32'(beam.hCount >= 9'(hActive)));
			if (beam.hCount == 9'd0 && prevH == 9'(hTotal - 1)) begin
				if (lineStarted) begin
					checks++;
					assert (syncMoved) else begin
						$display("sync stayed constant for a whole line before vCount %0d",
							beam.vCount);
						errors++;
					end
				end
				lineStarted = 1'b1;
				syncMoved = 1'b0;
				lastSync = sync;
			end else if (sync != lastSync) begin
				syncMoved = 1'b1;
			end
			prevH = beam.hCount;
		end

		// Sequential write and read-back, modulo 1
		writeReg(lspcPkg::regVramMod, 16'd1);
		d = lcgNext();
		base = {2'b00, d[13:0]};		// Clear of the fix map
		writeReg(lspcPkg::regVramAddr, base);
		for (int i = 0; i < 8; i++) begin
			words[i] = lcgNext();
			writeReg(lspcPkg::regVramData, words[i]);
		end
		writeReg(lspcPkg::regVramAddr, base);
		for (int i = 0; i < 8; i++) begin
			readReg(lspcPkg::regVramData, d);
			checkVal("vramData", 32'(d), 32'(words[i]));
			readReg(lspcPkg::regVramAddr, d);
			checkVal("vramAddr", 32'(d), 32'(base) + 32'(i) + 32'd1);
		end

		// Column stepping, modulo 32
		writeReg(lspcPkg::regVramMod, 16'd32);
		d = lcgNext();
		base = {2'b00, d[13:0]};
		writeReg(lspcPkg::regVramAddr, base);
		for (int i = 0; i < 3; i++) begin
			words[i] = lcgNext();
			writeReg(lspcPkg::regVramData, words[i]);
		end
		writeReg(lspcPkg::regVramAddr, base);
		for (int i = 0; i < 3; i++) begin
			readReg(lspcPkg::regVramAddr, d);
			checkVal("vramAddr", 32'(d), 32'(base) + 32'(i * 32));
			readReg(lspcPkg::regVramData, d);
			checkVal("vramData", 32'(d), 32'(words[i]));
		end

		// Fix map entry for column 2, row 1
		d = lcgNext();
		pal = d[15:12];
		tile = d[11:0];
		writeReg(lspcPkg::regVramAddr, {1'b0, lspcPkg::fixMapBase + 15'(2 * 32 + 1)});
		writeReg(lspcPkg::regVramData, {pal, tile});
		waitUntil(condVBlank, frameCycles + 200, "vblank before fix cell", w);
		waitUntil(condFixCell, frameCycles + 200, "fix cell row 1 column 2", w);
		fixExp = {tile, 2'b11, 3'b001};		// Pixel 6 of the cell, line 1 of the cell
		checkVal("fixOut.fixPal", 32'(fixBus.fixPal), 32'(pal));
		checkVal("fixOut.fixRomAddr", 32'(fixBus.fixRomAddr), 32'(fixExp));

		// Auto-animation, one step per two frames
		waitUntil(condVBlank, frameCycles + 200, "vblank", w);
		waitUntil(condActive, frameCycles + 200, "active area", w);
		mw = '0;
		mw.writeView.aaSpeed = 8'd1;
		writeReg(lspcPkg::regMode, mw);
		readReg(lspcPkg::regMode, d);
		mw = d;
		aaBase = mw.readView.aaCount;
		for (int f = 1; f <= 6; f++) begin
			waitUntil(condVBlank, frameCycles + 200, "vblank", w);
			idleCycles(4);		// Counter steps just after vblank starts
			readReg(lspcPkg::regMode, d);
			mw = d;
			checkVal("aaCount", 32'(mw.readView.aaCount), 32'(3'(aaBase + 3'(f / 2))));
			waitUntil(condActive, frameCycles + 200, "active area", w);
		end
		mw = '0;
		mw.writeView.aaSpeed = 8'd1;
		mw.writeView.aaDisable = 1'b1;
		writeReg(lspcPkg::regMode, mw);
		readReg(lspcPkg::regMode, d);
		mw = d;
		aaBase = mw.readView.aaCount;
		for (int f = 1; f <= 4; f++) begin
			waitUntil(condVBlank, frameCycles + 200, "vblank", w);
			idleCycles(4);
			readReg(lspcPkg::regMode, d);
			mw = d;
			checkVal("aaCount", 32'(mw.readView.aaCount), 32'(aaBase));	// Frozen
			waitUntil(condActive, frameCycles + 200, "active area", w);
		end

		$display("checks=%0d errors=%0d timeouts=%0d", checks, errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

// File: dv/lspcVideoChecks_sva.sv
`timescale 1ns/1ps
`default_nettype none

module lspcVideoChecks #(
	parameter int hTotal = 384
) (
	input logic SNKCLK_26,
	input logic resetP,
	input logic pixelEn,
	input logic [1:0] ipl,
	input lspcPkg::beamPos beam
);

	// Latches cleared on the first reset cycle, so look one cycle in
	iplInReset: assert property (
		@(posedge SNKCLK_26) disable iff ($isunknown(resetP))
			(!resetP && $past(!resetP)) |-> (ipl == 2'd0)
	) else $error("ipl nonzero while resetP low");

	hCountRange: assert property (
		@(posedge SNKCLK_26) disable iff (!resetP)
			beam.hCount < 9'(hTotal)		// Wrap before hTotal
	) else $error("hCount reached hTotal");

	// One cycle in four, never back to back
	pixelEnSingle: assert property (
		@(posedge SNKCLK_26) disable iff (!resetP)
			pixelEn |=> !pixelEn
	) else $error("pixelEn high on consecutive cycles");

endmodule

bind lspcVideo lspcVideoChecks #(
	.hTotal(hTotal)
) checks (
	.SNKCLK_26(SNKCLK_26),
	.resetP(resetP),
	.pixelEn(pixelEn),
	.ipl(ipl),
	.beam(beam)
);

`default_nettype wire

// File: design/lspcVideo.sv
`timescale 1ns/1ps
`default_nettype none

module lspcVideo #(
	parameter int hTotal = 384,
	parameter int vTotal = 264,
	parameter int hActive = 320,
	parameter int vActive = 224
) (
	input logic SNKCLK_26,
	input logic rstN,
	input lspcPkg::cpuBus cpu,
	output logic [15:0] readData,
	output lspcPkg::beamPos beam,
	output lspcPkg::fixOut fixOut,
	output logic [1:0] ipl,
	output logic sync,
	output logic resetP,
	output logic pixelEn
);

	logic slotPhase;				// 0 = fix fetch slot, 1 = CPU slot
	logic vblankStart;
	logic fetchEn;
	logic [14:0] fetchAddr;
	logic [15:0] fetchData;
	lspcPkg::modeWord modeW;
	logic [2:0] ackBits;
	logic [2:0] aaCount;

	clockReset clkRst (
		.SNKCLK_26(SNKCLK_26),
		.rstN(rstN),
		.resetP(resetP),
		.pixelEn(pixelEn),
		.slotPhase(slotPhase)
	);

	videoSync #(
		.hTotal(hTotal),
		.vTotal(vTotal),
		.hActive(hActive),
		.vActive(vActive)
	) vSync (
		.SNKCLK_26(SNKCLK_26),
		.resetP(resetP),
		.pixelEn(pixelEn),
		.beam(beam),
		.vblankStart(vblankStart),
		.sync(sync)
	);

	vramPort vram (
		.SNKCLK_26(SNKCLK_26),
		.resetP(resetP),
		.slotPhase(slotPhase),
		.cpu(cpu),
		.beam(beam),
		.readData(readData),
		.fetchEn(fetchEn),
		.fetchAddr(fetchAddr),
		.fetchData(fetchData),
		.aaCount(aaCount),
		.modeW(modeW),
		.ackBits(ackBits)
	);

	fixFetch #(
		.hActive(hActive),
		.vActive(vActive)
	) fix (
		.SNKCLK_26(SNKCLK_26),
		.resetP(resetP),
		.pixelEn(pixelEn),
		.slotPhase(slotPhase),
		.beam(beam),
		.fetchEn(fetchEn),
		.fetchAddr(fetchAddr),
		.fetchData(fetchData),
		.fixOut(fixOut)
	);

	autoAnim aa (
		.SNKCLK_26(SNKCLK_26),
		.resetP(resetP),
		.vblankStart(vblankStart),
		.modeW(modeW),
		.aaCount(aaCount)
	);

	irqCtrl irq (
		.SNKCLK_26(SNKCLK_26),
		.resetP(resetP),
		.vblankStart(vblankStart),
		.ackBits(ackBits),
		.ipl(ipl)
	);

endmodule

`default_nettype wire

// File: design/irqCtrl.sv
`timescale 1ns/1ps
`default_nettype none

module irqCtrl (
	input logic SNKCLK_26,
	input logic resetP,
	input logic vblankStart,
	input logic [2:0] ackBits,
	output logic [1:0] ipl
);

	logic resetSeen;		// Low for the first cycle after release
	logic pendReset;		// Level 3
	logic pendVblank;		// Level 1

	always_ff @(posedge SNKCLK_26) begin
		if (!resetP) begin
			resetSeen <= 1'b0;
			pendReset <= 1'b0;
			pendVblank <= 1'b0;
		end else begin
			resetSeen <= 1'b1;
			if (ackBits[0])
				pendReset <= 1'b0;
			if (ackBits[2])
				pendVblank <= 1'b0;
			// Ack bit 1 belonged to the timer
			if (!resetSeen)
				pendReset <= 1'b1;		// resetP rising edge
			if (vblankStart)
				pendVblank <= 1'b1;
		end
	end

	// Highest pending level wins
	assign ipl = pendReset ? 2'd3 : (pendVblank ? 2'd1 : 2'd0);

endmodule

`default_nettype wire

// File: design/autoAnim.sv
`timescale 1ns/1ps
`default_nettype none

module autoAnim (
	input logic SNKCLK_26,
	input logic resetP,
	input logic vblankStart,
	input lspcPkg::modeWord modeW,
	output logic [2:0] aaCount
);

	logic [7:0] frameCnt;		// Frames since last anim step
	logic frameDone;

	assign frameDone = (frameCnt == modeW.writeView.aaSpeed);

	always_ff @(posedge SNKCLK_26) begin
		if (!resetP) begin
			frameCnt <= '0;
			aaCount <= '0;
		end else if (vblankStart) begin
			if (frameDone) begin
				frameCnt <= '0;		// Reload
				// Timer keeps running while disabled
				if (!modeW.writeView.aaDisable)
					aaCount <= aaCount + 3'd1;	// Wraps mod 8
			end else begin
				frameCnt <= frameCnt + 8'd1;
			end
		end
	end

endmodule

`default_nettype wire

// File: design/fixFetch.sv
`timescale 1ns/1ps
`default_nettype none

module fixFetch #(
	parameter int hActive = 320,
	parameter int vActive = 224
) (
	input logic SNKCLK_26,
	input logic resetP,
	input logic pixelEn,
	input logic slotPhase,
	input lspcPkg::beamPos beam,
	output logic fetchEn,
	output logic [14:0] fetchAddr,
	input logic [15:0] fetchData,
	output lspcPkg::fixOut fixOut
);

	localparam logic [8:0] hEnd = 9'(hActive);
	localparam logic [8:0] vEnd = 9'(vActive);

	logic beamStepped;		// Beam took its new value last cycle
	logic cellStart;
	logic reqPending;		// Waiting for a fetch slot
	logic dataValid;
	logic [11:0] tileNb;
	logic [3:0] tilePal;

	assign cellStart = beamStepped && (beam.hCount[2:0] == 3'd0)
		&& (beam.hCount < hEnd) && (beam.vCount < vEnd);

	assign fetchEn = reqPending && !slotPhase;

	always_ff @(posedge SNKCLK_26) begin
		if (!resetP) begin
			beamStepped <= 1'b0;
			reqPending <= 1'b0;
			dataValid <= 1'b0;
		end else begin
			beamStepped <= pixelEn;
			dataValid <= fetchEn;		// RAM answers next cycle
			if (cellStart)
				reqPending <= 1'b1;
			else if (fetchEn)
				reqPending <= 1'b0;
		end
	end

	always_ff @(posedge SNKCLK_26) begin
		if (cellStart)	// Map is column-major, 32 words per column
			fetchAddr <= lspcPkg::fixMapBase + {4'b0, beam.hCount[8:3], 5'b0}
				+ {9'b0, beam.vCount[8:3]};
		if (dataValid) begin
			tilePal <= fetchData[15:12];
			tileNb <= fetchData[11:0];
		end
	end

	// Tile, half-column, line within cell
	assign fixOut.fixRomAddr = {tileNb, beam.hCount[2:1], beam.vCount[2:0]};
	assign fixOut.fixPal = tilePal;

endmodule

`default_nettype wire

// File: design/vramPort.sv
`timescale 1ns/1ps
`default_nettype none

module vramPort (
	input logic SNKCLK_26,
	input logic resetP,
	input logic slotPhase,
	input lspcPkg::cpuBus cpu,
	input lspcPkg::beamPos beam,
	output logic [15:0] readData,
	input logic fetchEn,
	input logic [14:0] fetchAddr,
	output logic [15:0] fetchData,
	input logic [2:0] aaCount,
	output lspcPkg::modeWord modeW,
	output logic [2:0] ackBits
);

	// Pending CPU-side VRAM operation
	localparam logic [1:0] opNone = 2'd0;
	localparam logic [1:0] opWrite = 2'd1;		// Store wrBuf, then step
	localparam logic [1:0] opPrefetch = 2'd2;	// Load readBuf at vramAddr
	localparam logic [1:0] opStep = 2'd3;		// Step, load readBuf at new address

	logic [15:0] vram [32768];
	logic [14:0] vramAddr;
	logic [14:0] nextAddr;
	logic [15:0] modReg;
	logic [15:0] wrBuf;
	logic [15:0] readBuf;		// Prefetched word for data reads
	logic [1:0] pendOp;
	lspcPkg::modeWord modeRd;

	assign nextAddr = vramAddr + modReg[14:0];	// Wraps at 15 bits

	always_comb begin
		modeRd = '0;
		modeRd.readView.vCount = beam.vCount;
		modeRd.readView.aaCount = aaCount;
	end

	// Strobe is one cycle, so is the ack pulse
	assign ackBits = (cpu.wrEn && cpu.regSel == lspcPkg::regIrqAck) ? cpu.wrData[2:0] : 3'b000;

	always_ff @(posedge SNKCLK_26) begin
		if (!resetP) begin
			vramAddr <= '0;
			modReg <= '0;
			modeW <= '0;
			pendOp <= opNone;
		end else begin
			// CPU slot retires whatever is pending
			if (slotPhase && pendOp != opNone) begin
				if (pendOp != opPrefetch)
					vramAddr <= nextAddr;
				pendOp <= opNone;
			end
			if (cpu.wrEn) begin
				case (cpu.regSel)
					lspcPkg::regVramAddr: begin
						vramAddr <= cpu.wrData[14:0];
						pendOp <= opPrefetch;
					end
					lspcPkg::regVramData: pendOp <= opWrite;
					lspcPkg::regVramMod: modReg <= cpu.wrData;
					lspcPkg::regMode: modeW <= cpu.wrData;
					default: ;
				endcase
			end
			if (cpu.rdEn && cpu.regSel == lspcPkg::regVramData)
				pendOp <= opStep;		// Next word ready for next read
		end
	end

	// Single RAM port, shared by slot
	always_ff @(posedge SNKCLK_26) begin
		if (!slotPhase) begin
			if (fetchEn)
				fetchData <= vram[fetchAddr];
		end else begin
			case (pendOp)
				opWrite: vram[vramAddr] <= wrBuf;
				opPrefetch: readBuf <= vram[vramAddr];
				opStep: readBuf <= vram[nextAddr];
				default: ;
			endcase
		end
	end

	always_ff @(posedge SNKCLK_26) begin
		if (cpu.wrEn && cpu.regSel == lspcPkg::regVramData)
			wrBuf <= cpu.wrData;
		if (cpu.rdEn) begin
			case (cpu.regSel)
				lspcPkg::regVramAddr: readData <= {1'b0, vramAddr};
				lspcPkg::regVramData: readData <= readBuf;
				lspcPkg::regVramMod: readData <= modReg;
				lspcPkg::regMode: readData <= modeRd;
				default: readData <= '0;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: design/videoSync.sv
`timescale 1ns/1ps
`default_nettype none

module videoSync #(
	parameter int hTotal = 384,
	parameter int vTotal = 264,
	parameter int hActive = 320,
	parameter int vActive = 224
) (
	input logic SNKCLK_26,
	input logic resetP,
	input logic pixelEn,
	output lspcPkg::beamPos beam,
	output logic vblankStart,
	output logic sync
);

	localparam logic [8:0] hLast = 9'(hTotal - 1);
	localparam logic [8:0] vLast = 9'(vTotal - 1);
	localparam logic [8:0] hBlankStart = 9'(hActive);
	localparam logic [8:0] vBlankStart = 9'(vActive);
	localparam logic [8:0] vPreBlank = 9'(vActive - 1);
	localparam logic [8:0] hSyncEnd = 9'(hActive + 8);	// 8 pixels of hsync
	localparam logic [8:0] vSyncEnd = 9'(vActive + 3);	// 3 lines of vsync

	logic [8:0] hCount;
	logic [8:0] vCount;
	logic lineEnd;
	logic hBlank;
	logic vBlank;
	logic hSync;
	logic vSyncN;

	assign lineEnd = (hCount == hLast);

	always_ff @(posedge SNKCLK_26) begin
		if (!resetP) begin
			hCount <= '0;
			vCount <= '0;
			vblankStart <= 1'b0;
		end else begin
			vblankStart <= 1'b0;
			if (pixelEn) begin
				if (lineEnd) begin
					hCount <= '0;
					if (vCount == vLast)
						vCount <= '0;		// Frame wrap
					else
						vCount <= vCount + 9'd1;
					// Fires together with vCount reaching vActive
					vblankStart <= (vCount == vPreBlank);
				end else begin
					hCount <= hCount + 9'd1;
				end
			end
		end
	end

	assign hBlank = (hCount >= hBlankStart);
	assign vBlank = (vCount >= vBlankStart);

	// Syncs sit at the start of each blanking interval
	assign hSync = hBlank && (hCount < hSyncEnd);
	assign vSyncN = !(vBlank && (vCount < vSyncEnd));
	assign sync = vSyncN ^ hSync;		// Composite

	assign beam = '{hCount: hCount, vCount: vCount, vBlank: vBlank, hBlank: hBlank};

endmodule

`default_nettype wire

// File: design/clockReset.sv
`timescale 1ns/1ps
`default_nettype none

module clockReset (
	input logic SNKCLK_26,
	input logic rstN,
	output logic resetP,
	output logic pixelEn,
	output logic slotPhase
);

	localparam logic [1:0] stretchLast = 2'd1;	// Extra cycles after sync

	logic [1:0] rstSync;		// Two-flop synchroniser
	logic [1:0] stretchCnt;
	logic [1:0] divCnt;			// 26 MHz / 4 pixel clock

	always_ff @(posedge SNKCLK_26) begin
		rstSync <= {rstSync[0], rstN};
		if (!rstSync[1]) begin
			stretchCnt <= '0;
			resetP <= 1'b0;
		end else if (stretchCnt == stretchLast) begin
			resetP <= 1'b1;				// Release, counter parks here
		end else begin
			stretchCnt <= stretchCnt + 2'd1;
		end
	end

	// Pixel enable and slot phase stay quiet while in reset
	always_ff @(posedge SNKCLK_26) begin
		if (!resetP) begin
			divCnt <= '0;
			pixelEn <= 1'b0;
			slotPhase <= 1'b0;
		end else begin
			divCnt <= divCnt + 2'd1;
			pixelEn <= (divCnt == 2'd3);	// One cycle in four
			if (pixelEn)
				slotPhase <= ~slotPhase;
		end
	end

endmodule

`default_nettype wire

// File: design/lspcPkg.sv
`default_nettype none

package lspcPkg;

	// CPU register indices, from address bits 3:1
	localparam logic [2:0] regVramAddr = 3'd0;
	localparam logic [2:0] regVramData = 3'd1;
	localparam logic [2:0] regVramMod = 3'd2;
	localparam logic [2:0] regMode = 3'd3;
	localparam logic [2:0] regIrqAck = 3'd6;

	localparam logic [14:0] fixMapBase = 15'h7000;	// Fix map at top of slow VRAM

	typedef struct packed {
		logic [8:0] hCount;
		logic [8:0] vCount;
		logic vBlank;
		logic hBlank;
	} beamPos;

	typedef struct packed {
		logic wrEn;			// One-cycle write strobe
		logic rdEn;			// One-cycle read strobe
		logic [2:0] regSel;
		logic [15:0] wrData;
	} cpuBus;

	// Same register, different meaning for writes and reads
	typedef union packed {
		struct packed {
			logic [7:0] aaSpeed;	// Frames per anim step, minus one
			logic [3:0] rsvdHi;
			logic aaDisable;
			logic [2:0] rsvdLo;
		} writeView;
		struct packed {
			logic [8:0] vCount;
			logic [3:0] rsvd;
			logic [2:0] aaCount;
		} readView;
	} modeWord;

	typedef struct packed {
		logic [16:0] fixRomAddr;
		logic [3:0] fixPal;
	} fixOut;

endpackage

`default_nettype wire
